/* rtl/flow_settings.svh */
`ifndef FLOW_SETTINGS_SVH
`define FLOW_SETTINGS_SVH

// Sample and running sum width, sums wrap here
`define FLOW_DATA_W 32

// Frame length width
`define FLOW_LEN_W 16

`endif

/* rtl/flow_ctrl_pkg.sv */
`default_nettype none

package flow_ctrl_pkg;

    // Port counts of the join/fork controller
    localparam int FLOW_NUM_INPUTS  = 2;
    localparam int FLOW_NUM_OUTPUTS = 2;

    // Stream positions inside a mask
    localparam int FLOW_BIT_SAMPLE = 0; // Sample in, running sum out
    localparam int FLOW_BIT_FRAME  = 1; // Length in, frame total out

    // One bit per stream
    typedef logic [1:0] flow_mask_t;

endpackage

`default_nettype wire

/* rtl/frame_pkg.sv */
`default_nettype none

`include "flow_settings.svh"

package frame_pkg;

    typedef logic [`FLOW_DATA_W-1:0] sample_t;

    typedef logic [`FLOW_LEN_W-1:0] frame_len_t;

    // One beat per accepted sample
    typedef struct packed {
        sample_t sum;   // Prefix sum including this sample
        logic    last;  // Final sample of the frame
    } sum_beat_t;

    // One beat per frame
    typedef struct packed {
        sample_t    total;
        frame_len_t count;
    } frame_total_t;

endpackage

`default_nettype wire

/* rtl/flow_join_fork.sv */
`timescale 1ns/100ps
`default_nettype none

module flow_join_fork
    import flow_ctrl_pkg::*;
#(
    parameter int NUM_INPUTS  = 2,
    parameter int NUM_OUTPUTS = 2
) (
    input  logic [NUM_INPUTS-1:0]  valid_in,
    output logic [NUM_INPUTS-1:0]  ready_in,

    output logic [NUM_OUTPUTS-1:0] valid_out,
    input  logic [NUM_OUTPUTS-1:0] ready_out,

    input  flow_mask_t             consume,
    input  flow_mask_t             produce,
    output logic                   fire
);

    logic [NUM_INPUTS-1:0]  in_sel;
    logic [NUM_OUTPUTS-1:0] out_sel;
    logic                   inputs_ok;
    logic                   outputs_ok;
    logic                   any_sel;

    assign in_sel  = consume[NUM_INPUTS-1:0];
    assign out_sel = produce[NUM_OUTPUTS-1:0];

    // Streams outside the masks never block
    assign inputs_ok  = &(valid_in | ~in_sel);
    assign outputs_ok = &(ready_out | ~out_sel);
    assign any_sel    = (|in_sel) || (|out_sel);

    assign fire = inputs_ok && outputs_ok && any_sel;

    // Fire fans back out as per-stream strobes
    assign ready_in  = in_sel & {NUM_INPUTS{fire}};
    assign valid_out = out_sel & {NUM_OUTPUTS{fire}};

    // The masks arrive from another module, so check what the joined streams saw
    always_comb begin
        if (fire) begin
            assert #0 ((valid_in & ready_in) == in_sel)
                else $error("join fired with a consumed input not valid");
            assert #0 ((ready_out & valid_out) == out_sel)
                else $error("fork fired into an output that was not ready");
            assert #0 (consume != '0 || produce != '0)
                else $error("fire with empty consume and produce masks");
        end
    end

endmodule

`default_nettype wire

/* rtl/flow_skid_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module flow_skid_stage #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,

    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,

    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);

    logic skid_valid;
    logic skid_valid_n;
    logic out_valid_n;
    T     skid_data;
    logic accept;
    logic main_free;

    assign accept    = in_valid && in_ready;
    assign main_free = !out_valid || out_ready; // Output reg empty or draining

    always_comb begin
        out_valid_n  = out_valid;
        skid_valid_n = skid_valid;
        if (main_free) begin
            // Skid entry drains first, in_ready is low while it is full
            out_valid_n  = skid_valid || accept;
            skid_valid_n = 1'b0;
        end else if (accept) begin
            skid_valid_n = 1'b1; // Output stalled, park the beat
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            out_valid  <= out_valid_n;
            skid_valid <= skid_valid_n;
            in_ready   <= !skid_valid_n;
        end
    end

    always_ff @(posedge clk) begin
        if (main_free) begin
            if (skid_valid) begin
                out_data <= skid_data;
            end else if (accept) begin
                out_data <= in_data;
            end
        end else if (accept) begin
            skid_data <= in_data;
        end
    end

    // Stalled beat must be held unchanged
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("skid stage output changed while stalled");

endmodule

`default_nettype wire

/* rtl/frame_accumulator.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_accumulator
    import flow_ctrl_pkg::*;
    import frame_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    input  logic         fire,
    input  sample_t      sample,
    input  frame_len_t   len,

    output flow_mask_t   consume,
    output flow_mask_t   produce,

    output sum_beat_t    sum_beat,
    output frame_total_t total
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACTIVE,
        ST_ZERO_EMIT
    } acc_state_t;

    acc_state_t state;
    logic       armed;        // Low in the first cycle after reset
    frame_len_t remaining;
    frame_len_t frame_len;
    sample_t    acc;
    sample_t    next_sum;
    logic       last_sample;

    assign last_sample = remaining == frame_len_t'(1);
    assign next_sum    = acc + sample; // Wraps at data width

    // Masks come from registers only
    always_comb begin
        consume = '0;
        produce = '0;
        if (armed) begin
            case (state)
                ST_IDLE: consume[FLOW_BIT_FRAME] = 1'b1;
                ST_ACTIVE: begin
                    consume[FLOW_BIT_SAMPLE] = 1'b1;
                    produce[FLOW_BIT_SAMPLE] = 1'b1;
                    produce[FLOW_BIT_FRAME]  = last_sample;
                end
                ST_ZERO_EMIT: produce[FLOW_BIT_FRAME] = 1'b1;
                default: ;
            endcase
        end
    end

    always_comb begin
        sum_beat.sum  = next_sum;
        sum_beat.last = last_sample;
        total.total   = (state == ST_ZERO_EMIT) ? '0 : next_sum;
        total.count   = frame_len; // Zero for an empty frame
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            armed     <= 1'b0;
            remaining <= '0;
        end else begin
            armed <= 1'b1;
            if (fire) begin
                case (state)
                    ST_IDLE: begin
                        remaining <= len;
                        state     <= (len == '0) ? ST_ZERO_EMIT : ST_ACTIVE;
                    end
                    ST_ACTIVE: begin
                        remaining <= remaining - frame_len_t'(1);
                        if (last_sample) state <= ST_IDLE;
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire && state == ST_IDLE) begin
            frame_len <= len;
            acc       <= '0;
        end else if (fire && state == ST_ACTIVE) begin
            acc <= next_sum;
        end
    end

    // Frame ends by leaving ACTIVE before the count runs out
    assert property (@(posedge clk) disable iff (rst)
        state == ST_ACTIVE |-> remaining != '0)
        else $error("active frame with zero samples remaining");

endmodule

`default_nettype wire

/* rtl/frame_sum_top.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_sum_top
    import flow_ctrl_pkg::*;
    import frame_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    input  logic         sample_valid,
    output logic         sample_ready,
    input  sample_t      sample,

    input  logic         len_valid,
    output logic         len_ready,
    input  frame_len_t   len,

    output logic         sum_valid,
    input  logic         sum_ready,
    output sum_beat_t    sum_beat,

    output logic         total_valid,
    input  logic         total_ready,
    output frame_total_t total
);

    flow_mask_t                  consume;
    flow_mask_t                  produce;
    logic                        fire;
    logic [FLOW_NUM_OUTPUTS-1:0] stage_valid;
    logic [FLOW_NUM_OUTPUTS-1:0] stage_ready;
    sum_beat_t                   acc_sum_beat;
    frame_total_t                acc_total;

    flow_join_fork #(
        .NUM_INPUTS  (FLOW_NUM_INPUTS),
        .NUM_OUTPUTS (FLOW_NUM_OUTPUTS)
    ) i_flow_join_fork (
        .valid_in  ({len_valid, sample_valid}),
        .ready_in  ({len_ready, sample_ready}),
        .valid_out (stage_valid),
        .ready_out (stage_ready),
        .consume   (consume),
        .produce   (produce),
        .fire      (fire)
    );

    frame_accumulator i_frame_accumulator (
        .clk      (clk),
        .rst      (rst),
        .fire     (fire),
        .sample   (sample),
        .len      (len),
        .consume  (consume),
        .produce  (produce),
        .sum_beat (acc_sum_beat),
        .total    (acc_total)
    );

    flow_skid_stage #(.T(sum_beat_t)) i_sum_stage (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (stage_valid[FLOW_BIT_SAMPLE]),
        .in_ready  (stage_ready[FLOW_BIT_SAMPLE]),
        .in_data   (acc_sum_beat),
        .out_valid (sum_valid),
        .out_ready (sum_ready),
        .out_data  (sum_beat)
    );

    flow_skid_stage #(.T(frame_total_t)) i_total_stage (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (stage_valid[FLOW_BIT_FRAME]),
        .in_ready  (stage_ready[FLOW_BIT_FRAME]),
        .in_data   (acc_total),
        .out_valid (total_valid),
        .out_ready (total_ready),
        .out_data  (total)
    );

endmodule

`default_nettype wire

/* dv/frame_sum_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_sum_tb
    import frame_pkg::*;
();

    localparam int CLK_HALF    = 20;
    localparam int RST_CYCLES  = 10;
    localparam int MAX_LEN     = 12;
    localparam int RAND_FRAMES = 10;
    // Directed frames give 17 beats, each random frame up to MAX_LEN + 1
    localparam int MAX_BEATS   = 17 + RAND_FRAMES * (MAX_LEN + 1);
    localparam int WATCHDOG_NS = MAX_BEATS * 2 * CLK_HALF * 20 + RST_CYCLES * 2 * CLK_HALF;

    logic         clk;
    logic         rst;
    logic         sample_valid;
    logic         sample_ready;
    sample_t      sample;
    logic         len_valid;
    logic         len_ready;
    frame_len_t   len;
    logic         sum_valid;
    logic         sum_ready;
    sum_beat_t    sum_beat;
    logic         total_valid;
    logic         total_ready;
    frame_total_t total;

    int           sum_errors;
    int           total_errors;
    int           proto_errors;
    sum_beat_t    exp_sums[$];
    frame_total_t exp_totals[$];
    sample_t      frame_buf [0:MAX_LEN-1];
    logic         bp_mode;
    logic [31:0]  data_rng;
    logic [31:0]  ready_rng;

    frame_sum_top i_frame_sum_top (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .sample       (sample),
        .len_valid    (len_valid),
        .len_ready    (len_ready),
        .len          (len),
        .sum_valid    (sum_valid),
        .sum_ready    (sum_ready),
        .sum_beat     (sum_beat),
        .total_valid  (total_valid),
        .total_ready  (total_ready),
        .total        (total)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_sum_beat(input sum_beat_t got, input sum_beat_t exp);
        if (got.sum !== exp.sum) begin
            sum_errors++;
            $display("FAILED at %0t: running sum 0x%08h, expected 0x%08h",
                     $time, got.sum, exp.sum);
        end
        if (got.last !== exp.last) begin
            sum_errors++;
            $display("FAILED at %0t: last flag %b, expected %b", $time, got.last, exp.last);
        end
    endtask

    task automatic check_total(input frame_total_t got, input frame_total_t exp);
        if (got.total !== exp.total) begin
            total_errors++;
            $display("FAILED at %0t: frame total 0x%08h, expected 0x%08h",
                     $time, got.total, exp.total);
        end
        if (got.count !== exp.count) begin
            total_errors++;
            $display("FAILED at %0t: sample count %0d, expected %0d",
                     $time, got.count, exp.count);
        end
    endtask

    task automatic check_outputs_quiet(input string when);
        if (sum_valid !== 1'b0 || total_valid !== 1'b0 ||
            sample_ready !== 1'b0 || len_ready !== 1'b0) begin
            proto_errors++;
            $display("Handshake signal raised %s at %0t", when, $time);
        end
    endtask

    // Reference model of one frame taken from frame_buf
    task automatic expect_frame(input frame_len_t n);
        int           i;
        sample_t      run;
        sum_beat_t    b;
        frame_total_t t;
        run = '0;
        for (i = 0; i < n; i++) begin
            run    = run + frame_buf[i];
            b.sum  = run;
            b.last = (i == n - 1);
            exp_sums.push_back(b);
        end
        t.total = run;
        t.count = n;
        exp_totals.push_back(t);
    endtask

    task automatic send_frame(input frame_len_t n);
        int i;
        expect_frame(n);
        @(posedge clk);
        len_valid <= 1'b1;
        len       <= n;
        do @(negedge clk); while (!len_ready);
        @(posedge clk);
        len_valid <= 1'b0;
        for (i = 0; i < n; i++) begin
            sample_valid <= 1'b1;
            sample       <= frame_buf[i];
            do @(negedge clk); while (!sample_ready);
            @(posedge clk);
        end
        sample_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_sums.size() != 0 || exp_totals.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    task automatic test_single_frame();
        frame_buf[0] = 32'd3;
        frame_buf[1] = 32'd5;
        frame_buf[2] = 32'd7;
        frame_buf[3] = 32'd11;
        send_frame(4);
        wait_drain();
    endtask

    task automatic test_wrap_total();
        frame_buf[0] = 32'hffff_fff0;
        frame_buf[1] = 32'h0000_0020;
        frame_buf[2] = 32'h0000_0005;
        send_frame(3);
        wait_drain();
    endtask

    task automatic test_zero_length();
        send_frame(0);
        frame_buf[0] = 32'd100;
        frame_buf[1] = 32'd23;
        send_frame(2);
        wait_drain();
    endtask

    task automatic test_back_pressure();
        int         f;
        int         i;
        frame_len_t n;
        @(posedge clk);
        bp_mode <= 1'b1;
        for (f = 0; f < RAND_FRAMES; f++) begin
            data_rng = xorshift32(data_rng);
            n        = frame_len_t'(data_rng % (MAX_LEN + 1));
            for (i = 0; i < n; i++) begin
                data_rng     = xorshift32(data_rng);
                frame_buf[i] = data_rng;
            end
            send_frame(n);
        end
        wait_drain();
        @(posedge clk);
        bp_mode <= 1'b0;
    endtask

    task automatic test_sample_before_length();
        frame_buf[0] = 32'd9;
        frame_buf[1] = 32'd40;
        frame_buf[2] = 32'd1;
        @(posedge clk);
        sample_valid <= 1'b1;
        sample       <= frame_buf[0];
        repeat (6) begin
            @(negedge clk);
            if (sample_ready) begin
                proto_errors++;
                $display("Sample accepted before its length word at %0t", $time);
            end
        end
        send_frame(3);
        wait_drain();
    endtask

    // Random ready patterns only in back-pressure mode
    always @(posedge clk) begin
        if (bp_mode) begin
            ready_rng = xorshift32(ready_rng);
            sum_ready   <= ready_rng[0] | ready_rng[1];
            total_ready <= ready_rng[4];
        end else begin
            sum_ready   <= 1'b1;
            total_ready <= 1'b1;
        end
    end

    // Transfer happens on the next rising edge
    always @(negedge clk) begin
        if (!rst && sum_valid && sum_ready) begin
            if (exp_sums.size() == 0) begin
                proto_errors++;
                $display("Unexpected running-sum beat at %0t", $time);
            end else begin
                check_sum_beat(sum_beat, exp_sums.pop_front());
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && total_valid && total_ready) begin
            if (exp_totals.size() == 0) begin
                proto_errors++;
                $display("Unexpected frame-total beat at %0t", $time);
            end else begin
                check_total(total, exp_totals.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog timeout, the DUT stopped moving beats");
        $display("test failed");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        sample_valid = 1'b0;
        sample       = '0;
        len_valid    = 1'b0;
        len          = '0;
        sum_ready    = 1'b1;
        total_ready  = 1'b1;
        bp_mode      = 1'b0;
        sum_errors   = 0;
        total_errors = 0;
        proto_errors = 0;
        data_rng     = 32'd10225;
        ready_rng    = 32'd10225;

        // Registers are unknown until the first reset edge
        @(posedge clk);
        repeat (RST_CYCLES - 1) begin
            @(negedge clk);
            check_outputs_quiet("during reset");
            @(posedge clk);
        end
        rst <= 1'b0;
        @(negedge clk);
        check_outputs_quiet("in the first cycle after reset");

        test_single_frame();
        test_wrap_total();
        test_zero_length();
        test_back_pressure();
        test_sample_before_length();

        $display("sum errors %0d, total errors %0d, protocol errors %0d",
                 sum_errors, total_errors, proto_errors);
        if (sum_errors == 0 && total_errors == 0 && proto_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+rtl
rtl/flow_ctrl_pkg.sv
rtl/frame_pkg.sv
rtl/flow_join_fork.sv
rtl/flow_skid_stage.sv
rtl/frame_accumulator.sv
rtl/frame_sum_top.sv
dv/frame_sum_tb.sv

/* Bender.yml */
package:
  name: frame_sum

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/flow_ctrl_pkg.sv
      - rtl/frame_pkg.sv
      - rtl/flow_join_fork.sv
      - rtl/flow_skid_stage.sv
      - rtl/frame_accumulator.sv
      - rtl/frame_sum_top.sv
  - target: test
    files:
      - dv/frame_sum_tb.sv
